// ==== common/dmmu_pkg.sv ====
/*
 * Shared definitions for the data MMU subsystem.
 * Holds widths, the TLB entry layout, bus payload structs and the lookup result.
 * Modules import it inside their bodies and use scoped names in port lists.
 */
`default_nettype none

package dmmu_pkg;

   // Data and address width
   localparam int dw = 32;
   // Page offset bits
   localparam int page_shift = 13;
   // Virtual and physical page number widths
   localparam int vpn_w = dw - page_shift;
   localparam int ppn_w = dw - page_shift;
   // Widest TLB index the MSR window can carry
   localparam int tlb_idx_max_w = 7;

   // TLB low word, tag side
   typedef struct packed {
      logic [vpn_w-1:0] vpn;
      logic [11:0]      rsv;
      logic             v;
   } tlb_lo_t;

   // TLB high word, translation and attributes
   typedef struct packed {
      logic [ppn_w-1:0] ppn;
      logic [3:0]       rsv_hi;
      logic             sh;
      logic             nc;
      logic             rr;
      logic             rw;
      logic             ur;
      logic             uw;
      logic [1:0]       rsv_lo;
      logic             p;
   } tlb_hi_t;

   // Load/store command, write when any mask bit set
   typedef struct packed {
      logic [dw-1:0]   addr;
      logic [dw/8-1:0] wmsk;
      logic [dw-1:0]   wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic [dw-1:0] rdata;
   } mem_rsp_t;

   // One MSR write port per TLB half
   typedef struct packed {
      logic                     we;
      logic [tlb_idx_max_w-1:0] idx;
      logic [dw-1:0]            data;
   } msr_tlb_wr_t;

   typedef enum logic [1:0] {
      res_ok,
      res_miss,
      res_fault
   } access_result_e;

endpackage

`default_nettype wire

// ==== rtl/pipe_buf.sv ====
/*
 * One-entry valid/ready buffer with ready bypass.
 * Accepts a new item while empty or while the held one leaves,
 * and flags each accepted input transfer on cas.
 */
`default_nettype none

module pipe_buf #(
   parameter int DW = 1
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic          in_valid,
   output logic          in_ready,
   input  logic [DW-1:0] din,
   output logic          out_valid,
   input  logic          out_ready,
   output logic [DW-1:0] dout,
   output logic          cas
);

   logic valid_q;
   // Keeps the input side closed until reset has gone
   logic rdy_en_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdy_en_q <= 1'b0;
         valid_q  <= 1'b0;
      end else begin
         rdy_en_q <= 1'b1;
         if (cas) begin
            valid_q <= 1'b1;
         end else if (out_ready) begin
            valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cas) begin
         dout <= din;
      end
   end

   // Ready passes through from the output side
   assign in_ready  = rdy_en_q & (~valid_q | out_ready);
   assign cas       = in_valid & in_ready;
   assign out_valid = valid_q;

endmodule

`default_nettype wire

// ==== dmmu/tlb_ram.sv ====
/*
 * Single-clock true dual-port RAM for one half of the TLB.
 * Port A is the read-only lookup port, port B the MSR read/write window.
 * A port B write is forwarded to port A when both hit the same entry.
 */
`default_nettype none

module tlb_ram #(
   parameter int AW = 4,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic [AW-1:0] addr_a,
   input  logic          en_a,
   output logic [DW-1:0] dout_a,
   input  logic [AW-1:0] addr_b,
   input  logic          we_b,
   input  logic [DW-1:0] din_b,
   output logic [DW-1:0] dout_b
);

   logic [DW-1:0] mem [2**AW];
   logic          b2a_hit;

   // Same-cycle MSR write to the entry being looked up
   assign b2a_hit = we_b && (addr_b == addr_a);

   // Storage, no reset
   always_ff @(posedge clk) begin
      if (we_b) begin
         mem[addr_b] <= din_b;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dout_a <= '0;
         dout_b <= '0;
      end else begin
         // Lookup data only moves on an accepted command
         if (en_a) begin
            dout_a <= b2a_hit ? din_b : mem[addr_a];
         end
         // MSR side shows the entry after the write
         dout_b <= we_b ? din_b : mem[addr_b];
      end
   end

endmodule

`default_nettype wire

// ==== dmmu/dmmu.sv ====
/*
 * Data MMU between the load/store unit and the data memory.
 * Latches each command, looks up a direct-mapped TLB and forwards the
 * translated command, or raises a one-cycle miss or fault pulse instead.
 */
`default_nettype none

module dmmu #(
   parameter int TLB_NSETS_LOG2 = 4
) (
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   dbus_cmd_valid,
   output logic                                   dbus_cmd_ready,
   input  dmmu_pkg::mem_cmd_t                     dbus_cmd,
   input  logic                                   psr_dmme,
   input  logic                                   psr_rm,
   input  dmmu_pkg::msr_tlb_wr_t                  tlbl_wr,
   input  dmmu_pkg::msr_tlb_wr_t                  tlbh_wr,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0]     tlbl_idx,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0]     tlbh_idx,
   output logic [dmmu_pkg::dw-1:0]                tlbl_rd,
   output logic [dmmu_pkg::dw-1:0]                tlbh_rd,
   output logic [dmmu_pkg::dw-1:0]                dmmid,
   output logic                                   mem_cmd_valid,
   input  logic                                   mem_cmd_ready,
   output dmmu_pkg::mem_cmd_t                     mem_cmd,
   output logic                                   exp_tlb_miss,
   output logic                                   exp_page_fault
);
   import dmmu_pkg::*;

   // Identification word carries the set count
   localparam logic [2:0] nsets_id = 3'(TLB_NSETS_LOG2);

   logic                      buf_valid;
   logic                      cas;
   logic                      flush;
   logic [TLB_NSETS_LOG2-1:0] lookup_idx;
   logic [TLB_NSETS_LOG2-1:0] msr_lo_idx;
   logic [TLB_NSETS_LOG2-1:0] msr_hi_idx;
   mem_cmd_t                  cmd_r;
   logic                      dmme_r;
   logic                      rm_r;
   logic [dw-1:0]             tlb_lo_raw;
   logic [dw-1:0]             tlb_hi_raw;
   tlb_lo_t                   tlb_lo;
   tlb_hi_t                   tlb_hi;
   logic                      is_write;
   logic                      perm_denied;
   access_result_e            res;

   // Handshake only as cmd_r holds the command fields
   pipe_buf #(
      .DW (1)
   ) i_cmd_buf (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (dbus_cmd_valid),
      .in_ready  (dbus_cmd_ready),
      .din       (1'b0),
      .out_valid (buf_valid),
      .out_ready (mem_cmd_ready | flush),
      .dout      (),
      .cas       (cas)
   );

   // Set index from the low VPN bits of the incoming address
   assign lookup_idx = dbus_cmd.addr[page_shift +: TLB_NSETS_LOG2];

   // Mode bits sampled with the command
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dmme_r <= 1'b0;
         rm_r   <= 1'b0;
      end else if (cas) begin
         dmme_r <= psr_dmme;
         rm_r   <= psr_rm;
      end
   end

   always_ff @(posedge clk) begin
      if (cas) begin
         cmd_r <= dbus_cmd;
      end
   end

   // MSR window uses the write index while writing, else the read index
   assign msr_lo_idx = tlbl_wr.we ? tlbl_wr.idx[TLB_NSETS_LOG2-1:0]
                                  : tlbl_idx[TLB_NSETS_LOG2-1:0];
   assign msr_hi_idx = tlbh_wr.we ? tlbh_wr.idx[TLB_NSETS_LOG2-1:0]
                                  : tlbh_idx[TLB_NSETS_LOG2-1:0];

   tlb_ram #(
      .AW (TLB_NSETS_LOG2),
      .DW (dw)
   ) i_tlb_lo (
      .clk    (clk),
      .arst_n (arst_n),
      .addr_a (lookup_idx),
      .en_a   (cas),
      .dout_a (tlb_lo_raw),
      .addr_b (msr_lo_idx),
      .we_b   (tlbl_wr.we),
      .din_b  (tlbl_wr.data),
      .dout_b (tlbl_rd)
   );

   tlb_ram #(
      .AW (TLB_NSETS_LOG2),
      .DW (dw)
   ) i_tlb_hi (
      .clk    (clk),
      .arst_n (arst_n),
      .addr_a (lookup_idx),
      .en_a   (cas),
      .dout_a (tlb_hi_raw),
      .addr_b (msr_hi_idx),
      .we_b   (tlbh_wr.we),
      .din_b  (tlbh_wr.data),
      .dout_b (tlbh_rd)
   );

   assign tlb_lo = tlb_lo_raw;
   assign tlb_hi = tlb_hi_raw;

   assign is_write = |cmd_r.wmsk;

   // Root and user each have their own read and write flags
   assign perm_denied = rm_r ? (is_write ? ~tlb_hi.rw : ~tlb_hi.rr)
                             : (is_write ? ~tlb_hi.uw : ~tlb_hi.ur);

   // Miss wins over fault and neither applies with translation off
   always_comb begin
      res = res_ok;
      if (dmme_r) begin
         if (!tlb_lo.v || (tlb_lo.vpn != cmd_r.addr[dw-1:page_shift])) begin
            res = res_miss;
         end else if (perm_denied) begin
            res = res_fault;
         end
      end
   end

   // Pulse while the entry is held and release it through the flush
   assign exp_tlb_miss   = buf_valid && (res == res_miss);
   assign exp_page_fault = buf_valid && (res == res_fault);
   assign flush          = exp_tlb_miss | exp_page_fault;

   // Cancelled commands never reach the memory
   assign mem_cmd_valid = buf_valid & ~flush;

   // PPN plus page offset, or raw address with translation off
   always_comb begin
      mem_cmd = cmd_r;
      if (dmme_r) begin
         mem_cmd.addr = {tlb_hi.ppn, cmd_r.addr[page_shift-1:0]};
      end
   end

   assign dmmid = {{(dw-3){1'b0}}, nsets_id};

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
/*
 * Word-addressed data memory that stands in for the data cache.
 * Serves one command at a time and returns the word as it was before the
 * byte-masked write, held until the response is taken.
 */
`default_nettype none

module data_ram #(
   parameter int MEM_AW = 10
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  dmmu_pkg::mem_cmd_t cmd,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output dmmu_pkg::mem_rsp_t rsp
);
   import dmmu_pkg::*;

   logic [dw-1:0]     mem [2**MEM_AW];
   logic [MEM_AW-1:0] widx;
   logic              fire;

   // Word index, upper address bits ignored
   assign widx = cmd.addr[MEM_AW+1:2];

   // No new command while a response waits
   assign cmd_ready = ~rsp_valid;
   assign fire      = cmd_valid & cmd_ready;

   // Read old word and merge write bytes in the same cycle
   always_ff @(posedge clk) begin
      if (fire) begin
         rsp.rdata <= mem[widx];
      end
      for (int b = 0; b < dw/8; b++) begin
         if (fire && cmd.wmsk[b]) begin
            mem[widx][8*b +: 8] <= cmd.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid <= 1'b0;
      end else if (fire) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dmmu_subsys_top.sv ====
/*
 * Top level of the data memory subsystem.
 * Puts the data MMU in front of the data memory and exposes the
 * load/store buses, MSR TLB window and exception pulses.
 */
`default_nettype none

module dmmu_subsys_top #(
   parameter int TLB_NSETS_LOG2 = 4,
   parameter int MEM_AW         = 10
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               dbus_cmd_valid,
   output logic                               dbus_cmd_ready,
   input  dmmu_pkg::mem_cmd_t                 dbus_cmd,
   output logic                               dbus_rsp_valid,
   input  logic                               dbus_rsp_ready,
   output dmmu_pkg::mem_rsp_t                 dbus_rsp,
   input  logic                               psr_dmme,
   input  logic                               psr_rm,
   input  dmmu_pkg::msr_tlb_wr_t              tlbl_wr,
   input  dmmu_pkg::msr_tlb_wr_t              tlbh_wr,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0] tlbl_idx,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0] tlbh_idx,
   output logic [dmmu_pkg::dw-1:0]            tlbl_rd,
   output logic [dmmu_pkg::dw-1:0]            tlbh_rd,
   output logic [dmmu_pkg::dw-1:0]            dmmid,
   output logic                               exp_tlb_miss,
   output logic                               exp_page_fault
);
   import dmmu_pkg::*;

   // MMU to memory command link
   logic     mem_cmd_valid;
   logic     mem_cmd_ready;
   mem_cmd_t mem_cmd;

   dmmu #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) i_dmmu (
      .clk            (clk),
      .arst_n         (arst_n),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_cmd       (dbus_cmd),
      .psr_dmme       (psr_dmme),
      .psr_rm         (psr_rm),
      .tlbl_wr        (tlbl_wr),
      .tlbh_wr        (tlbh_wr),
      .tlbl_idx       (tlbl_idx),
      .tlbh_idx       (tlbh_idx),
      .tlbl_rd        (tlbl_rd),
      .tlbh_rd        (tlbh_rd),
      .dmmid          (dmmid),
      .mem_cmd_valid  (mem_cmd_valid),
      .mem_cmd_ready  (mem_cmd_ready),
      .mem_cmd        (mem_cmd),
      .exp_tlb_miss   (exp_tlb_miss),
      .exp_page_fault (exp_page_fault)
   );

   // Responses go straight back to the load/store unit
   data_ram #(
      .MEM_AW (MEM_AW)
   ) i_data_ram (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd_valid (mem_cmd_valid),
      .cmd_ready (mem_cmd_ready),
      .cmd       (mem_cmd),
      .rsp_valid (dbus_rsp_valid),
      .rsp_ready (dbus_rsp_ready),
      .rsp       (dbus_rsp)
   );

endmodule

`default_nettype wire

// ==== tests/dmmu_props.sv ====
/*
 * Concurrent assertions on the data MMU outputs, bound into dmmu.
 * Covers exception exclusivity, command cancellation and reset values.
 */
`default_nettype none

module dmmu_props (
   input logic clk,
   input logic arst_n,
   input logic dbus_cmd_valid,
   input logic dbus_cmd_ready,
   input logic mem_cmd_valid,
   input logic exp_tlb_miss,
   input logic exp_page_fault
);
   timeunit 1ns;
   timeprecision 100ps;

   logic exc;

   assign exc = exp_tlb_miss | exp_page_fault;

   a_exc_excl : assert property (@(posedge clk) disable iff (!arst_n)
      !(exp_tlb_miss && exp_page_fault))
      else $error("Miss and fault raised together");

   // Cancelled command is dropped and never offered to memory later
   a_cancel : assert property (@(posedge clk) disable iff (!arst_n)
      (exc && !(dbus_cmd_valid && dbus_cmd_ready)) |=> !mem_cmd_valid)
      else $error("Memory command offered after an exception");

   // Only a newly accepted command can raise the next pulse
   a_pulse : assert property (@(posedge clk) disable iff (!arst_n)
      (exc && !(dbus_cmd_valid && dbus_cmd_ready)) |=> !exc)
      else $error("Exception held longer than one cycle");

   a_reset : assert property (@(posedge clk)
      !arst_n |-> !(mem_cmd_valid || exc || dbus_cmd_ready))
      else $error("Output active during reset");

endmodule

bind dmmu dmmu_props i_dmmu_props (
   .clk            (clk),
   .arst_n         (arst_n),
   .dbus_cmd_valid (dbus_cmd_valid),
   .dbus_cmd_ready (dbus_cmd_ready),
   .mem_cmd_valid  (mem_cmd_valid),
   .exp_tlb_miss   (exp_tlb_miss),
   .exp_page_fault (exp_page_fault)
);

`default_nettype wire

// ==== tests/dmmu_checker.sv ====
/*
 * Scoreboard for the data MMU subsystem.
 * Keeps a shadow TLB and shadow memory from observed MSR writes and
 * commands, and compares exceptions, responses, MSR reads and the ID word.
 */
`default_nettype none

module dmmu_checker #(
   parameter int TLB_NSETS_LOG2 = 4,
   parameter int MEM_AW         = 10
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               dbus_cmd_valid,
   input  logic                               dbus_cmd_ready,
   input  dmmu_pkg::mem_cmd_t                 dbus_cmd,
   input  logic                               dbus_rsp_valid,
   input  logic                               dbus_rsp_ready,
   input  dmmu_pkg::mem_rsp_t                 dbus_rsp,
   input  logic                               psr_dmme,
   input  logic                               psr_rm,
   input  dmmu_pkg::msr_tlb_wr_t              tlbl_wr,
   input  dmmu_pkg::msr_tlb_wr_t              tlbh_wr,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0] tlbl_idx,
   input  logic [dmmu_pkg::tlb_idx_max_w-1:0] tlbh_idx,
   input  logic [dmmu_pkg::dw-1:0]            tlbl_rd,
   input  logic [dmmu_pkg::dw-1:0]            tlbh_rd,
   input  logic [dmmu_pkg::dw-1:0]            dmmid,
   input  logic                               exp_tlb_miss,
   input  logic                               exp_page_fault,
   output int                                 n_data_err,
   output int                                 n_exc_err,
   output int                                 n_msr_err
);
   timeunit 1ns;
   timeprecision 100ps;
   import dmmu_pkg::*;

   logic [dw-1:0]  sh_lo [2**TLB_NSETS_LOG2];
   logic [dw-1:0]  sh_hi [2**TLB_NSETS_LOG2];
   logic [dw-1:0]  sh_mem [2**MEM_AW];
   logic [dw-1:0]  rsp_q [$];
   logic [dw-1:0]  exp_lrd;
   logic [dw-1:0]  exp_hrd;
   logic           rd_chk = 1'b0;
   logic           pend_valid = 1'b0;
   access_result_e pend_res;

   initial begin
      n_data_err = 0;
      n_exc_err  = 0;
      n_msr_err  = 0;
   end

   // Miss before the permission check of mode and direction
   function automatic access_result_e predict(tlb_lo_t lo, tlb_hi_t hi, logic [dw-1:0] addr,
                                              logic wr, logic dmme, logic rm);
      logic allowed;
      if (!dmme) begin
         return res_ok;
      end
      if (!lo.v || lo.vpn != addr[dw-1:page_shift]) begin
         return res_miss;
      end
      if (rm) begin
         allowed = wr ? hi.rw : hi.rr;
      end else begin
         allowed = wr ? hi.uw : hi.ur;
      end
      return allowed ? res_ok : res_fault;
   endfunction

   // Sampled mid-cycle so each check describes the coming rising edge
   always @(negedge clk) begin : scoreboard
      logic [TLB_NSETS_LOG2-1:0] set;
      logic [dw-1:0]             pa;
      logic [dw-1:0]             exp_rdata;
      logic [MEM_AW-1:0]         w;
      access_result_e            r;
      if (!arst_n) begin
         rd_chk     = 1'b0;
         pend_valid = 1'b0;
         rsp_q.delete();
      end else begin
         // Identification word is a constant set count
         if (dmmid !== TLB_NSETS_LOG2) begin
            $display("Fail dmmid: got %h expected %h", dmmid, TLB_NSETS_LOG2);
            n_msr_err++;
         end

         // MSR read data lags its index by one cycle
         if (rd_chk && tlbl_rd !== exp_lrd) begin
            $display("Fail tlbl_rd: got %h expected %h", tlbl_rd, exp_lrd);
            n_msr_err++;
         end
         if (rd_chk && tlbh_rd !== exp_hrd) begin
            $display("Fail tlbh_rd: got %h expected %h", tlbh_rd, exp_hrd);
            n_msr_err++;
         end
         exp_lrd = tlbl_wr.we ? tlbl_wr.data : sh_lo[tlbl_idx[TLB_NSETS_LOG2-1:0]];
         exp_hrd = tlbh_wr.we ? tlbh_wr.data : sh_hi[tlbh_idx[TLB_NSETS_LOG2-1:0]];
         rd_chk  = 1'b1;

         if (exp_tlb_miss !== (pend_valid && pend_res == res_miss)) begin
            $display("Fail exp_tlb_miss: got %h expected %h", exp_tlb_miss,
                     pend_valid && pend_res == res_miss);
            n_exc_err++;
         end
         if (exp_page_fault !== (pend_valid && pend_res == res_fault)) begin
            $display("Fail exp_page_fault: got %h expected %h", exp_page_fault,
                     pend_valid && pend_res == res_fault);
            n_exc_err++;
         end
         pend_valid = 1'b0;

         // Responses in command order
         if (dbus_rsp_valid && dbus_rsp_ready) begin
            if (rsp_q.size() == 0) begin
               $display("Response arrived with no command outstanding");
               n_data_err++;
            end else begin
               exp_rdata = rsp_q.pop_front();
               if (dbus_rsp.rdata !== exp_rdata) begin
                  $display("Fail dbus_rsp.rdata: got %h expected %h", dbus_rsp.rdata, exp_rdata);
                  n_data_err++;
               end
            end
         end

         // TLB writes land before a same-edge lookup
         if (tlbl_wr.we) begin
            sh_lo[tlbl_wr.idx[TLB_NSETS_LOG2-1:0]] = tlbl_wr.data;
         end
         if (tlbh_wr.we) begin
            sh_hi[tlbh_wr.idx[TLB_NSETS_LOG2-1:0]] = tlbh_wr.data;
         end

         if (dbus_cmd_valid && dbus_cmd_ready) begin
            set = dbus_cmd.addr[page_shift +: TLB_NSETS_LOG2];
            r   = predict(sh_lo[set], sh_hi[set], dbus_cmd.addr, |dbus_cmd.wmsk,
                          psr_dmme, psr_rm);
            pend_valid = 1'b1;
            pend_res   = r;
            if (r == res_ok) begin
               pa = psr_dmme ? {sh_hi[set][dw-1:page_shift], dbus_cmd.addr[page_shift-1:0]}
                             : dbus_cmd.addr;
               w  = pa[MEM_AW+1:2];
               rsp_q.push_back(sh_mem[w]);
               for (int b = 0; b < dw/8; b++) begin
                  if (dbus_cmd.wmsk[b]) begin
                     sh_mem[w][8*b +: 8] = dbus_cmd.wdata[8*b +: 8];
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_dmmu_subsys.sv ====
/*
 * Testbench for the data MMU subsystem.
 * Applies a table of MSR writes, MSR reads and accesses, with random
 * response back-pressure, and reports the error counts at the end.
 */
`default_nettype none

module tb_dmmu_subsys;
   timeunit 1ns;
   timeprecision 100ps;
   import dmmu_pkg::*;

   localparam int nsets_log2 = 4;
   localparam int mem_aw     = 10;

   typedef enum logic [2:0] {k_tlbl, k_tlbh, k_msr_rd, k_acc, k_wr_acc} row_kind_e;
   typedef struct {
      row_kind_e                kind;
      logic                     dmme;
      logic                     rm;
      logic [tlb_idx_max_w-1:0] idx;
      logic [dw-1:0]            data;
      logic [dw-1:0]            addr;
      logic [3:0]               mask;
      access_result_e           exp;
      logic                     wait_done;
   } row_t;

   logic                     clk = 1'b0;
   logic                     arst_n;
   logic                     dbus_cmd_valid;
   logic                     dbus_cmd_ready;
   mem_cmd_t                 dbus_cmd;
   logic                     dbus_rsp_valid;
   logic                     dbus_rsp_ready;
   mem_rsp_t                 dbus_rsp;
   logic                     psr_dmme;
   logic                     psr_rm;
   msr_tlb_wr_t              tlbl_wr;
   msr_tlb_wr_t              tlbh_wr;
   logic [tlb_idx_max_w-1:0] tlbl_idx;
   logic [tlb_idx_max_w-1:0] tlbh_idx;
   logic [dw-1:0]            tlbl_rd;
   logic [dw-1:0]            tlbh_rd;
   logic [dw-1:0]            dmmid;
   logic                     exp_tlb_miss;
   logic                     exp_page_fault;
   int                       seed = 99;
   int                       n_rsp = 0;
   int                       n_ok_exp = 0;
   int                       n_tb_err = 0;
   int                       n_timeout = 0;
   int                       n_data_err;
   int                       n_exc_err;
   int                       n_msr_err;
   row_t                     rows [$];

   always #2 clk = ~clk;

   dmmu_subsys_top #(
      .TLB_NSETS_LOG2 (nsets_log2),
      .MEM_AW         (mem_aw)
   ) i_dmmu_subsys_top (.*);

   dmmu_checker #(
      .TLB_NSETS_LOG2 (nsets_log2),
      .MEM_AW         (mem_aw)
   ) i_checker (.*);

   // Random response back-pressure
   always @(posedge clk) begin
      dbus_rsp_ready <= arst_n && (($random(seed) & 3) != 0);
   end

   always @(negedge clk) begin
      if (arst_n && dbus_rsp_valid && dbus_rsp_ready) begin
         n_rsp <= n_rsp + 1;
      end
   end

   function automatic void add(row_kind_e k, logic dm, logic rm, logic [6:0] idx,
                               logic [31:0] data, logic [31:0] addr, logic [3:0] msk,
                               access_result_e ex, logic wt);
      rows.push_back('{k, dm, rm, idx, data, addr, msk, ex, wt});
   endfunction

   task automatic msr_write(input row_t r);
      @(posedge clk);
      if (r.kind == k_tlbl) begin
         tlbl_wr  <= '{1'b1, r.idx, r.data};
         tlbl_idx <= r.idx;
      end else begin
         tlbh_wr  <= '{1'b1, r.idx, r.data};
         tlbh_idx <= r.idx;
      end
      @(posedge clk);
      tlbl_wr.we <= 1'b0;
      tlbh_wr.we <= 1'b0;
   endtask

   task automatic wait_responses(input int limit);
      int t;
      t = 0;
      while (n_rsp < n_ok_exp && t < limit) begin
         @(negedge clk);
         t++;
      end
      if (n_rsp < n_ok_exp) begin
         $display("Timeout waiting for a response");
         n_timeout++;
      end
   endtask

   task automatic access(input row_t r);
      int             t;
      access_result_e got;
      @(posedge clk);
      dbus_cmd_valid <= 1'b1;
      dbus_cmd       <= '{r.addr, r.mask, r.data};
      psr_dmme       <= r.dmme;
      psr_rm         <= r.rm;
      // TLB write on the same edge as the lookup
      if (r.kind == k_wr_acc) begin
         tlbl_wr  <= '{1'b1, r.idx, r.data};
         tlbl_idx <= r.idx;
      end
      @(negedge clk);
      if (r.kind == k_wr_acc && !dbus_cmd_ready) begin
         $display("Command was not accepted together with the TLB write");
         n_tb_err++;
      end
      t = 0;
      while (!dbus_cmd_ready && t < 100) begin
         @(negedge clk);
         t++;
      end
      if (!dbus_cmd_ready) begin
         $display("Timeout waiting for the command to be accepted");
         n_timeout++;
      end
      @(posedge clk);
      dbus_cmd_valid <= 1'b0;
      tlbl_wr.we     <= 1'b0;
      if (r.exp == res_ok) begin
         n_ok_exp++;
         if (r.wait_done) begin
            wait_responses(200);
         end
      end else begin
         got = res_ok;
         t   = 0;
         while (got == res_ok && t < 4) begin
            @(negedge clk);
            if (exp_tlb_miss) begin
               got = res_miss;
            end else if (exp_page_fault) begin
               got = res_fault;
            end
            t++;
         end
         if (got != r.exp) begin
            $display("Fail exception outcome: got %h expected %h", got, r.exp);
            n_tb_err++;
         end
      end
   endtask

   initial begin
      arst_n         = 1'b0;
      dbus_cmd_valid = 1'b0;
      dbus_cmd       = '0;
      dbus_rsp_ready = 1'b0;
      psr_dmme       = 1'b0;
      psr_rm         = 1'b0;
      tlbl_wr        = '0;
      tlbh_wr        = '0;
      tlbl_idx       = '0;
      tlbh_idx       = '0;

      // Byte merges with translation off
      add(k_acc, 0, 0, 0, 32'h11223344, 32'h100, 4'hf, res_ok, 1);
      add(k_acc, 0, 0, 0, 32'haaaa5555, 32'h100, 4'h3, res_ok, 1);
      add(k_acc, 0, 0, 0, 32'hbeef0000, 32'h100, 4'hc, res_ok, 1);
      add(k_acc, 0, 0, 0, 32'h0, 32'h100, 4'h0, res_ok, 1);
      // Invalid entry and VPN mismatch
      add(k_tlbl, 0, 0, 2, 32'h4000, 0, 0, res_ok, 0);
      add(k_tlbh, 0, 0, 2, 32'ha079, 0, 0, res_ok, 0);
      add(k_acc, 1, 1, 0, 32'h0, 32'h4010, 4'h0, res_miss, 1);
      add(k_acc, 0, 1, 0, 32'h0, 32'h4010, 4'h0, res_ok, 1);
      add(k_tlbl, 0, 0, 3, 32'h26001, 0, 0, res_ok, 0);
      add(k_tlbh, 0, 0, 3, 32'ha079, 0, 0, res_ok, 0);
      add(k_acc, 1, 0, 0, 32'h0, 32'h6000, 4'h0, res_miss, 1);
      // Two virtual pages on one PPN
      add(k_acc, 1, 0, 0, 32'hcafef00d, 32'h26020, 4'hf, res_ok, 1);
      add(k_tlbl, 0, 0, 4, 32'h8001, 0, 0, res_ok, 0);
      add(k_tlbh, 0, 0, 4, 32'ha079, 0, 0, res_ok, 0);
      add(k_acc, 1, 0, 0, 32'h0, 32'h8020, 4'h0, res_ok, 1);
      // User read and root write permissions first
      add(k_tlbl, 0, 0, 5, 32'ha001, 0, 0, res_ok, 0);
      add(k_tlbh, 0, 0, 5, 32'hc031, 0, 0, res_ok, 0);
      add(k_acc, 1, 0, 0, 32'h12345678, 32'ha040, 4'hf, res_fault, 1);
      add(k_acc, 1, 0, 0, 32'h0, 32'ha040, 4'h0, res_ok, 1);
      add(k_acc, 1, 1, 0, 32'h0, 32'ha040, 4'h0, res_fault, 1);
      add(k_acc, 1, 1, 0, 32'h0badcafe, 32'ha040, 4'hf, res_ok, 1);
      // Then user write and root read
      add(k_tlbh, 0, 0, 5, 32'hc049, 0, 0, res_ok, 0);
      add(k_acc, 1, 0, 0, 32'h0, 32'ha040, 4'h0, res_fault, 1);
      add(k_acc, 1, 1, 0, 32'h0, 32'ha040, 4'h0, res_ok, 1);
      add(k_acc, 1, 1, 0, 32'hdeadbeef, 32'ha040, 4'hf, res_fault, 1);
      add(k_acc, 1, 0, 0, 32'h5a5a5a5a, 32'ha040, 4'h5, res_ok, 1);
      add(k_acc, 0, 0, 0, 32'h0, 32'h40, 4'h0, res_ok, 1);
      // Pipelined burst under back-pressure
      add(k_acc, 0, 0, 0, 32'h01010101, 32'h200, 4'hf, res_ok, 0);
      add(k_acc, 0, 0, 0, 32'h02020202, 32'h204, 4'hf, res_ok, 0);
      add(k_acc, 0, 0, 0, 32'h03030303, 32'h208, 4'h6, res_ok, 0);
      add(k_acc, 0, 0, 0, 32'h0, 32'h200, 4'h0, res_ok, 0);
      add(k_acc, 0, 0, 0, 32'h0, 32'h204, 4'h0, res_ok, 0);
      add(k_acc, 0, 0, 0, 32'h0, 32'h208, 4'h0, res_ok, 1);
      // MSR reads and same-cycle write bypass
      add(k_msr_rd, 0, 0, 5, 0, 0, 0, res_ok, 0);
      add(k_msr_rd, 0, 0, 3, 0, 0, 0, res_ok, 0);
      add(k_tlbl, 0, 0, 6, 32'hc000, 0, 0, res_ok, 0);
      add(k_tlbh, 0, 0, 6, 32'he079, 0, 0, res_ok, 0);
      add(k_wr_acc, 1, 0, 6, 32'hc001, 32'hc008, 4'h0, res_ok, 1);
      add(k_msr_rd, 0, 0, 6, 0, 0, 0, res_ok, 0);

      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      foreach (rows[i]) begin
         case (rows[i].kind)
            k_tlbl, k_tlbh: msr_write(rows[i]);
            k_msr_rd: begin
               @(posedge clk);
               tlbl_idx <= rows[i].idx;
               tlbh_idx <= rows[i].idx;
               repeat (2) @(posedge clk);
            end
            default: access(rows[i]);
         endcase
      end

      wait_responses(500);
      repeat (4) @(posedge clk);

      $display("Errors: data %0d, exception %0d, msr %0d, testbench %0d, timeouts %0d",
               n_data_err, n_exc_err, n_msr_err, n_tb_err, n_timeout);
      if (n_data_err + n_exc_err + n_msr_err + n_tb_err + n_timeout == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/dmmu_pkg.sv
rtl/pipe_buf.sv
dmmu/tlb_ram.sv
dmmu/dmmu.sv
rtl/data_ram.sv
rtl/dmmu_subsys_top.sv
tests/dmmu_props.sv
tests/dmmu_checker.sv
tests/tb_dmmu_subsys.sv
